/* flist.f */
src/mpmem_pkg.sv
src/mpmem_bank_arbiter.sv
src/mpmem_word_align.sv
src/mpmem_read_return.sv
src/mpmem_top.sv
sim/mpmem_bank_model.sv
sim/mpmem_checker.sv
sim/tb_mpmem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mpmem
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test build clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass message"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^ALL TESTS PASSED$$" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/tb_mpmem.sv */
module tb_mpmem;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUMADDR         = 1 << mpmem_pkg::BITADDR;
  localparam int RESET_CYCLES    = 4;
  localparam int RAND_CYCLES     = 1000;
  localparam int DIRECTED_CYCLES = 6 * NUMADDR;  // Six address passes at one op per cycle
  localparam int TEST_CYCLES     = RESET_CYCLES + mpmem_pkg::INIT_CYCLES + DIRECTED_CYCLES
                                   + RAND_CYCLES;
  localparam int TIMEOUT_CYCLES  = 2 * TEST_CYCLES;

  logic                                                  clk;
  logic                                                  arst_n;
  logic                                                  ready;
  logic [mpmem_pkg::NUMWRPT-1:0]                         write;
  logic [mpmem_pkg::NUMWRPT-1:0][mpmem_pkg::BITADDR-1:0] wr_adr;
  logic [mpmem_pkg::NUMWRPT-1:0][mpmem_pkg::WIDTH-1:0]   din;
  logic [mpmem_pkg::NUMWRPT-1:0]                         wr_gnt;
  logic [mpmem_pkg::NUMRDPT-1:0]                         read;
  logic [mpmem_pkg::NUMRDPT-1:0][mpmem_pkg::BITADDR-1:0] rd_adr;
  logic [mpmem_pkg::NUMRDPT-1:0]                         rd_gnt;
  logic [mpmem_pkg::NUMRDPT-1:0]                         rd_vld;
  logic [mpmem_pkg::NUMRDPT-1:0][mpmem_pkg::WIDTH-1:0]   rd_dout;
  logic [mpmem_pkg::NUMRDPT-1:0]                         rd_serr;
  logic [mpmem_pkg::NUMRDPT-1:0][mpmem_pkg::BITPADR-1:0] rd_padr;
  logic [mpmem_pkg::NUMVBNK-1:0]                         t1_writeA;
  logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::BITSROW-1:0] t1_addrA;
  logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::PHYWDTH-1:0] t1_bwA;
  logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::PHYWDTH-1:0] t1_dinA;
  logic [mpmem_pkg::NUMVBNK-1:0]                         t1_readB;
  logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::BITSROW-1:0] t1_addrB;
  logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::PHYWDTH-1:0] t1_doutB;

  logic [mpmem_pkg::BITADDR+mpmem_pkg::WIDTH-1:0] wq [mpmem_pkg::NUMWRPT][$];  // {adr, data}
  logic [mpmem_pkg::BITADDR-1:0]                  rq [mpmem_pkg::NUMRDPT][$];
  logic [mpmem_pkg::NUMWRPT-1:0]                  wr_seen;
  logic [mpmem_pkg::NUMRDPT-1:0]                  rd_seen;
  logic [mpmem_pkg::NUMWRPT-1:0]                  prev_wr;
  logic [mpmem_pkg::NUMRDPT-1:0]                  prev_rd;
  bit                                             watch_rr;
  int                                             cyc;
  int                                             tb_err;
  int                                             tests_run;
  int                                             tests_failed;

  mpmem_top mpmem_top_i (.*);

  mpmem_checker chk_i (.*);

  for (genvar b = 0; b < mpmem_pkg::NUMVBNK; b++) begin : g_model
    mpmem_bank_model u_model (
      .clk    (clk),
      .writeA (t1_writeA[b]),
      .addrA  (t1_addrA[b]),
      .bwA    (t1_bwA[b]),
      .dinA   (t1_dinA[b]),
      .readB  (t1_readB[b]),
      .addrB  (t1_addrB[b]),
      .doutB  (t1_doutB[b])
    );
  end

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    wr_seen <= wr_gnt;
    rd_seen <= rd_gnt;
    cyc++;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the run did not finish", cyc);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // Both ports request the same bank here, so winners must alternate
  always @(posedge clk) begin
    if (watch_rr && write == '1 && wr_gnt != '0) begin
      if (wr_gnt == prev_wr) begin
        $display("Write grant went to the same port twice in a row at %0t", $time);
        tb_err++;
      end
      prev_wr = wr_gnt;
    end
    if (watch_rr && read == '1 && rd_gnt != '0) begin
      if (rd_gnt == prev_rd) begin
        $display("Read grant went to the same port twice in a row at %0t", $time);
        tb_err++;
      end
      prev_rd = rd_gnt;
    end
  end

  // Each port holds its request until granted, then takes the next one queued
  always @(negedge clk) begin
    for (int p = 0; p < mpmem_pkg::NUMWRPT; p++) begin
      if (write[p] && wr_seen[p]) write[p] = 1'b0;
      if (!write[p] && wq[p].size() > 0) begin
        {wr_adr[p], din[p]} = wq[p].pop_front();
        write[p] = 1'b1;
      end
    end
    for (int p = 0; p < mpmem_pkg::NUMRDPT; p++) begin
      if (read[p] && rd_seen[p]) read[p] = 1'b0;
      if (!read[p] && rq[p].size() > 0) begin
        rd_adr[p] = rq[p].pop_front();
        read[p] = 1'b1;
      end
    end
  end

  function automatic bit queues_empty();
    bit e;
    e = 1'b1;
    for (int p = 0; p < mpmem_pkg::NUMWRPT; p++) if (wq[p].size() > 0) e = 1'b0;
    for (int p = 0; p < mpmem_pkg::NUMRDPT; p++) if (rq[p].size() > 0) e = 1'b0;
    return e;
  endfunction

  task automatic wait_idle();
    int quiet;
    quiet = 0;
    while (quiet < mpmem_pkg::RD_LAT + 2) begin
      @(negedge clk);
      #1;
      if (write == '0 && read == '0 && queues_empty()) quiet++;
      else quiet = 0;
    end
  endtask

  function automatic logic [mpmem_pkg::BITADDR-1:0] make_adr(input int srow, input int wrd,
                                                             input int vbnk);
    mpmem_pkg::mpmem_addr_u a;
    a.fld.srow = mpmem_pkg::BITSROW'(srow);
    a.fld.wrd  = mpmem_pkg::BITWRDS'(wrd);
    a.fld.vbnk = mpmem_pkg::BITVBNK'(vbnk);
    return a.flat;
  endfunction

  task automatic read_all();
    for (int i = 0; i < NUMADDR; i++) rq[i % mpmem_pkg::NUMRDPT].push_back(7'(i));
    wait_idle();
  endtask

  task automatic write_slots(input int wrd);
    mpmem_pkg::mpmem_addr_u a;
    for (int i = 0; i < NUMADDR; i++) begin
      a.flat = 7'(i);
      if (int'(a.fld.wrd) == wrd) begin
        wq[i % mpmem_pkg::NUMWRPT].push_back({a.flat, 16'(i * 16'h0203 + 1)});
      end
    end
    wait_idle();
  endtask

  task automatic inject_parity_flip(input logic [mpmem_pkg::BITADDR-1:0] adr);
    mpmem_pkg::mpmem_addr_u a;
    int                     bit_idx;
    a.flat  = adr;
    bit_idx = int'(a.fld.wrd) * mpmem_pkg::MEMWDTH + mpmem_pkg::WIDTH;  // Parity bit of slot
    case (a.fld.vbnk)
      2'd0: g_model[0].u_model.flip_bit(int'(a.fld.srow), bit_idx);
      2'd1: g_model[1].u_model.flip_bit(int'(a.fld.srow), bit_idx);
      2'd2: g_model[2].u_model.flip_bit(int'(a.fld.srow), bit_idx);
      default: g_model[3].u_model.flip_bit(int'(a.fld.srow), bit_idx);
    endcase
    chk_i.mark_corrupt(adr);
  endtask

  task automatic end_test(input string name, input int err_before);
    int errs;
    errs = tb_err + chk_i.err_cnt - err_before;
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("test %0d %s: %s (%0d errors)", tests_run, name, errs == 0 ? "ok" : "failed", errs);
  endtask

  initial begin
    int e0;
    int n;
    void'($urandom(32'h758a));
    arst_n   = 1'b0;
    write    = '0;
    wr_adr   = '0;
    din      = '0;
    read     = '0;
    rd_adr   = '0;
    watch_rr = 1'b0;
    prev_wr  = '0;
    prev_rd  = '0;
    cyc      = 0;
    tb_err   = 0;

    // Reset and init
    e0 = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    if (ready !== 1'b0) begin
      $display("CHECK FAILED t=%0t ready expected 0 got %b", $time, ready);
      tb_err++;
    end
    arst_n = 1'b1;
    n = 0;
    while (!ready) begin
      @(negedge clk);
      n++;
    end
    if (n != mpmem_pkg::INIT_CYCLES + 1) begin
      $display("ready rose %0d cycles after reset, expected %0d", n, mpmem_pkg::INIT_CYCLES + 1);
      tb_err++;
    end
    for (int i = 0; i < 16; i++) rq[i % 2].push_back(7'(i * 7));
    wait_idle();
    end_test("reset and init", e0);

    // Neighbor slots must keep zero until written themselves
    e0 = tb_err + chk_i.err_cnt;
    write_slots(0);
    read_all();
    write_slots(1);
    read_all();
    end_test("write then read", e0);

    e0 = tb_err + chk_i.err_cnt;
    watch_rr = 1'b1;
    for (int i = 0; i < 4; i++) begin
      wq[0].push_back({make_adr(i, 0, 0), 16'(16'ha000 + i)});
      wq[1].push_back({make_adr(i, 1, 0), 16'(16'hb000 + i)});
    end
    wait_idle();
    for (int i = 0; i < 4; i++) begin
      rq[0].push_back(make_adr(i, 0, 0));
      rq[1].push_back(make_adr(i, 1, 0));
    end
    wait_idle();
    watch_rr = 1'b0;
    end_test("contention", e0);

    // Read and write of one address go out in the same cycle
    e0 = tb_err + chk_i.err_cnt;
    wq[0].push_back({make_adr(5, 1, 2), 16'hdead});
    rq[1].push_back(make_adr(5, 1, 2));
    wait_idle();
    rq[0].push_back(make_adr(5, 1, 2));
    wait_idle();
    end_test("same-row read and write", e0);

    e0 = tb_err + chk_i.err_cnt;
    for (int c = 0; c < RAND_CYCLES; c++) begin
      @(negedge clk);
      #1;
      for (int p = 0; p < 2; p++) begin
        if (wq[p].size() < 2 && $urandom % 2 == 0) wq[p].push_back(23'($urandom));
        if (rq[p].size() < 2 && $urandom % 2 == 0) rq[p].push_back(7'($urandom));
      end
    end
    wait_idle();
    end_test("random traffic", e0);

    e0 = tb_err + chk_i.err_cnt;
    wq[0].push_back({7'h25, 16'h1234});
    wait_idle();
    inject_parity_flip(7'h25);
    read_all();
    wq[1].push_back({7'h25, 16'h4321});  // A rewrite clears the error
    wait_idle();
    rq[0].push_back(7'h25);
    wait_idle();
    end_test("parity error", e0);

    $display("tests run %0d, passed %0d, failed %0d, read checks %0d",
             tests_run, tests_run - tests_failed, tests_failed, chk_i.chk_cnt);
    if (tests_failed == 0 && tb_err + chk_i.err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* sim/mpmem_checker.sv */
module mpmem_checker (
  input logic                                                  clk,
  input logic                                                  arst_n,
  input logic [mpmem_pkg::NUMWRPT-1:0]                         write,
  input logic [mpmem_pkg::NUMWRPT-1:0][mpmem_pkg::BITADDR-1:0] wr_adr,
  input logic [mpmem_pkg::NUMWRPT-1:0][mpmem_pkg::WIDTH-1:0]   din,
  input logic [mpmem_pkg::NUMWRPT-1:0]                         wr_gnt,
  input logic [mpmem_pkg::NUMRDPT-1:0]                         read,
  input logic [mpmem_pkg::NUMRDPT-1:0][mpmem_pkg::BITADDR-1:0] rd_adr,
  input logic [mpmem_pkg::NUMRDPT-1:0]                         rd_gnt,
  input logic [mpmem_pkg::NUMRDPT-1:0]                         rd_vld,
  input logic [mpmem_pkg::NUMRDPT-1:0][mpmem_pkg::WIDTH-1:0]   rd_dout,
  input logic [mpmem_pkg::NUMRDPT-1:0]                         rd_serr,
  input logic [mpmem_pkg::NUMRDPT-1:0][mpmem_pkg::BITPADR-1:0] rd_padr
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUMADDR = 1 << mpmem_pkg::BITADDR;

  typedef struct packed {
    logic [mpmem_pkg::WIDTH-1:0]   data;
    logic [mpmem_pkg::BITPADR-1:0] padr;
    logic                          serr;
  } rd_exp_t;

  typedef struct packed {
    logic [31:0] port;
    logic [31:0] due;
    rd_exp_t     exp;
  } pend_t;

  logic [mpmem_pkg::WIDTH-1:0] shadow [NUMADDR];
  logic                        corrupt [NUMADDR];
  pend_t                       pend_q [$];
  int                          cyc;
  int                          err_cnt;
  int                          chk_cnt;

  initial begin
    foreach (shadow[i]) begin
      shadow[i]  = '0;  // Init sweep leaves every word at zero
      corrupt[i] = 1'b0;
    end
    cyc     = 0;
    err_cnt = 0;
    chk_cnt = 0;
  end

  function automatic rd_exp_t expect_read(input logic [mpmem_pkg::BITADDR-1:0] adr);
    mpmem_pkg::mpmem_addr_u a;
    rd_exp_t                e;
    a.flat = adr;
    e.data = shadow[adr];
    e.padr = {a.fld.vbnk, a.fld.srow, a.fld.wrd};
    e.serr = corrupt[adr];
    return e;
  endfunction

  task automatic mark_corrupt(input logic [mpmem_pkg::BITADDR-1:0] adr);
    corrupt[adr] = 1'b1;
  endtask

  always @(posedge clk) begin : compare
    pend_t e;
    bit    found;
    if (arst_n) begin
      cyc++;
      for (int p = 0; p < mpmem_pkg::NUMRDPT; p++) begin
        found = 1'b0;
        foreach (pend_q[i]) begin
          if (pend_q[i].port == 32'(p) && pend_q[i].due == 32'(cyc)) begin
            found = 1'b1;
            e     = pend_q[i];
          end
        end
        if (found && !rd_vld[p]) begin
          $display("read port %0d: rd_vld missing at %0t", p, $time);
          err_cnt++;
        end else if (!found && rd_vld[p]) begin
          $display("read port %0d: rd_vld with no read pending at %0t", p, $time);
          err_cnt++;
        end else if (found) begin
          chk_cnt++;
          if (rd_dout[p] !== e.exp.data) begin
            $display("CHECK FAILED t=%0t rd_dout[%0d] expected %h got %h",
                     $time, p, e.exp.data, rd_dout[p]);
            err_cnt++;
          end
          if (rd_padr[p] !== e.exp.padr) begin
            $display("CHECK FAILED t=%0t rd_padr[%0d] expected %h got %h",
                     $time, p, e.exp.padr, rd_padr[p]);
            err_cnt++;
          end
          if (rd_serr[p] !== e.exp.serr) begin
            $display("CHECK FAILED t=%0t rd_serr[%0d] expected %b got %b",
                     $time, p, e.exp.serr, rd_serr[p]);
            err_cnt++;
          end
        end
      end
      while (pend_q.size() > 0 && pend_q[0].due <= 32'(cyc)) void'(pend_q.pop_front());
      // Reads take the old data, so they go before this edge's writes
      for (int p = 0; p < mpmem_pkg::NUMRDPT; p++) begin
        if (rd_gnt[p] && !read[p]) begin
          $display("read port %0d granted with no request at %0t", p, $time);
          err_cnt++;
        end else if (rd_gnt[p]) begin
          e.port = 32'(p);
          e.due  = 32'(cyc + mpmem_pkg::RD_LAT + 1);  // Seen one edge after rd_vld rises
          e.exp  = expect_read(rd_adr[p]);
          pend_q.push_back(e);
        end
      end
      for (int p = 0; p < mpmem_pkg::NUMWRPT; p++) begin
        if (wr_gnt[p] && !write[p]) begin
          $display("write port %0d granted with no request at %0t", p, $time);
          err_cnt++;
        end else if (wr_gnt[p]) begin
          shadow[wr_adr[p]]  = din[p];
          corrupt[wr_adr[p]] = 1'b0;
        end
      end
    end
  end

endmodule

/* sim/mpmem_bank_model.sv */
module mpmem_bank_model (
  input  logic                          clk,
  input  logic                          writeA,
  input  logic [mpmem_pkg::BITSROW-1:0] addrA,
  input  logic [mpmem_pkg::PHYWDTH-1:0] bwA,
  input  logic [mpmem_pkg::PHYWDTH-1:0] dinA,
  input  logic                          readB,
  input  logic [mpmem_pkg::BITSROW-1:0] addrB,
  output logic [mpmem_pkg::PHYWDTH-1:0] doutB
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [mpmem_pkg::PHYWDTH-1:0] mem [mpmem_pkg::NUMSROW];

  // Read sees the row as it was before a write on the same edge
  always @(posedge clk) begin
    if (readB) doutB <= mem[addrB];
    if (writeA) mem[addrA] <= (mem[addrA] & ~bwA) | (dinA & bwA);
  end

  // Backdoor access for error injection
  task automatic flip_bit(input int row, input int bit_idx);
    mem[row][bit_idx] = ~mem[row][bit_idx];
  endtask

endmodule

/* src/mpmem_top.sv */
module mpmem_top (
  input  logic                                                   clk,
  input  logic                                                   arst_n,
  output logic                                                   ready,
  input  logic [mpmem_pkg::NUMWRPT-1:0]                          write,
  input  logic [mpmem_pkg::NUMWRPT-1:0][mpmem_pkg::BITADDR-1:0]  wr_adr,
  input  logic [mpmem_pkg::NUMWRPT-1:0][mpmem_pkg::WIDTH-1:0]    din,
  output logic [mpmem_pkg::NUMWRPT-1:0]                          wr_gnt,
  input  logic [mpmem_pkg::NUMRDPT-1:0]                          read,
  input  logic [mpmem_pkg::NUMRDPT-1:0][mpmem_pkg::BITADDR-1:0]  rd_adr,
  output logic [mpmem_pkg::NUMRDPT-1:0]                          rd_gnt,
  output logic [mpmem_pkg::NUMRDPT-1:0]                          rd_vld,
  output logic [mpmem_pkg::NUMRDPT-1:0][mpmem_pkg::WIDTH-1:0]    rd_dout,
  output logic [mpmem_pkg::NUMRDPT-1:0]                          rd_serr,
  output logic [mpmem_pkg::NUMRDPT-1:0][mpmem_pkg::BITPADR-1:0]  rd_padr,
  output logic [mpmem_pkg::NUMVBNK-1:0]                          t1_writeA,
  output logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::BITSROW-1:0]  t1_addrA,
  output logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::PHYWDTH-1:0]  t1_bwA,
  output logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::PHYWDTH-1:0]  t1_dinA,
  output logic [mpmem_pkg::NUMVBNK-1:0]                          t1_readB,
  output logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::BITSROW-1:0]  t1_addrB,
  input  logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::PHYWDTH-1:0]  t1_doutB
);

  logic [mpmem_pkg::NUMVBNK-1:0]                         bk_write;
  logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::BITSROW-1:0] bk_wr_srow;
  logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::BITWRDS-1:0] bk_wr_wrd;
  logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::WIDTH-1:0]   bk_din;
  logic [mpmem_pkg::NUMVBNK-1:0]                         bk_read;
  logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::BITSROW-1:0] bk_rd_srow;
  logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::BITWRDS-1:0] bk_rd_wrd;
  logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::BITRDPT-1:0] bk_rd_port;
  logic [mpmem_pkg::NUMVBNK-1:0]                         al_vld;
  logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::WIDTH-1:0]   al_dout;
  logic [mpmem_pkg::NUMVBNK-1:0]                         al_serr;
  logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::BITPADR-1:0] al_padr;

  mpmem_bank_arbiter u_arb (
    .clk        (clk),
    .arst_n     (arst_n),
    .write      (write),
    .wr_adr     (wr_adr),
    .din        (din),
    .read       (read),
    .rd_adr     (rd_adr),
    .wr_gnt     (wr_gnt),
    .rd_gnt     (rd_gnt),
    .ready      (ready),
    .bk_write   (bk_write),
    .bk_wr_srow (bk_wr_srow),
    .bk_wr_wrd  (bk_wr_wrd),
    .bk_din     (bk_din),
    .bk_read    (bk_read),
    .bk_rd_srow (bk_rd_srow),
    .bk_rd_wrd  (bk_rd_wrd),
    .bk_rd_port (bk_rd_port)
  );

  for (genvar b = 0; b < mpmem_pkg::NUMVBNK; b++) begin : g_bank
    mpmem_word_align #(.BANK_ID(b)) u_align (
      .clk        (clk),
      .arst_n     (arst_n),
      .bk_write   (bk_write[b]),
      .bk_wr_srow (bk_wr_srow[b]),
      .bk_wr_wrd  (bk_wr_wrd[b]),
      .bk_din     (bk_din[b]),
      .bk_read    (bk_read[b]),
      .bk_rd_srow (bk_rd_srow[b]),
      .bk_rd_wrd  (bk_rd_wrd[b]),
      .t1_writeA  (t1_writeA[b]),
      .t1_addrA   (t1_addrA[b]),
      .t1_bwA     (t1_bwA[b]),
      .t1_dinA    (t1_dinA[b]),
      .t1_readB   (t1_readB[b]),
      .t1_addrB   (t1_addrB[b]),
      .t1_doutB   (t1_doutB[b]),
      .al_vld     (al_vld[b]),
      .al_dout    (al_dout[b]),
      .al_serr    (al_serr[b]),
      .al_padr    (al_padr[b])
    );
  end

  mpmem_read_return u_ret (
    .clk        (clk),
    .arst_n     (arst_n),
    .bk_rd_port (bk_rd_port),
    .bk_read    (bk_read),
    .al_vld     (al_vld),
    .al_dout    (al_dout),
    .al_serr    (al_serr),
    .al_padr    (al_padr),
    .rd_vld     (rd_vld),
    .rd_dout    (rd_dout),
    .rd_serr    (rd_serr),
    .rd_padr    (rd_padr)
  );

endmodule

/* src/mpmem_read_return.sv */
module mpmem_read_return (
  input  logic                                                   clk,
  input  logic                                                   arst_n,
  input  logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::BITRDPT-1:0]  bk_rd_port,
  input  logic [mpmem_pkg::NUMVBNK-1:0]                          bk_read,
  input  logic [mpmem_pkg::NUMVBNK-1:0]                          al_vld,
  input  logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::WIDTH-1:0]    al_dout,
  input  logic [mpmem_pkg::NUMVBNK-1:0]                          al_serr,
  input  logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::BITPADR-1:0]  al_padr,
  output logic [mpmem_pkg::NUMRDPT-1:0]                          rd_vld,
  output logic [mpmem_pkg::NUMRDPT-1:0][mpmem_pkg::WIDTH-1:0]    rd_dout,
  output logic [mpmem_pkg::NUMRDPT-1:0]                          rd_serr,
  output logic [mpmem_pkg::NUMRDPT-1:0][mpmem_pkg::BITPADR-1:0]  rd_padr
);

  logic [mpmem_pkg::BITRDPT-1:0] port_pipe [mpmem_pkg::NUMVBNK][mpmem_pkg::RD_LAT];

  logic [mpmem_pkg::NUMRDPT-1:0]                         vld_nxt;
  logic [mpmem_pkg::NUMRDPT-1:0][mpmem_pkg::WIDTH-1:0]   dout_nxt;
  logic [mpmem_pkg::NUMRDPT-1:0]                         serr_nxt;
  logic [mpmem_pkg::NUMRDPT-1:0][mpmem_pkg::BITPADR-1:0] padr_nxt;

  // Port index follows the read through the SRAM and aligner stages
  always_ff @(posedge clk) begin
    for (int b = 0; b < mpmem_pkg::NUMVBNK; b++) begin
      if (bk_read[b]) port_pipe[b][0] <= bk_rd_port[b];
      for (int s = 1; s < mpmem_pkg::RD_LAT; s++) port_pipe[b][s] <= port_pipe[b][s-1];
    end
  end

  always_comb begin
    vld_nxt  = '0;
    dout_nxt = '0;
    serr_nxt = '0;
    padr_nxt = '0;
    for (int p = 0; p < mpmem_pkg::NUMRDPT; p++) begin
      for (int b = 0; b < mpmem_pkg::NUMVBNK; b++) begin
        if (al_vld[b] && int'(port_pipe[b][mpmem_pkg::RD_LAT-1]) == p) begin
          vld_nxt[p]  = 1'b1;
          dout_nxt[p] = al_dout[b];
          serr_nxt[p] = al_serr[b];
          padr_nxt[p] = al_padr[b];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_vld <= '0;
    end else begin
      rd_vld <= vld_nxt;
    end
  end

  always_ff @(posedge clk) begin
    rd_dout <= dout_nxt;
    rd_serr <= serr_nxt;
    rd_padr <= padr_nxt;
  end

endmodule

/* src/mpmem_word_align.sv */
module mpmem_word_align #(
  parameter int BANK_ID = 0
) (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              bk_write,
  input  logic [mpmem_pkg::BITSROW-1:0]     bk_wr_srow,
  input  logic [mpmem_pkg::BITWRDS-1:0]     bk_wr_wrd,
  input  logic [mpmem_pkg::WIDTH-1:0]       bk_din,
  input  logic                              bk_read,
  input  logic [mpmem_pkg::BITSROW-1:0]     bk_rd_srow,
  input  logic [mpmem_pkg::BITWRDS-1:0]     bk_rd_wrd,
  output logic                              t1_writeA,
  output logic [mpmem_pkg::BITSROW-1:0]     t1_addrA,
  output logic [mpmem_pkg::PHYWDTH-1:0]     t1_bwA,
  output logic [mpmem_pkg::PHYWDTH-1:0]     t1_dinA,
  output logic                              t1_readB,
  output logic [mpmem_pkg::BITSROW-1:0]     t1_addrB,
  input  logic [mpmem_pkg::PHYWDTH-1:0]     t1_doutB,
  output logic                              al_vld,
  output logic [mpmem_pkg::WIDTH-1:0]       al_dout,
  output logic                              al_serr,
  output logic [mpmem_pkg::BITPADR-1:0]     al_padr
);

  logic [mpmem_pkg::MEMWDTH-1:0]    wr_slot;
  logic [mpmem_pkg::MEMWDTH-1:0]    rd_slot;
  logic [mpmem_pkg::SRAM_DELAY-1:0] pipe_vld;
  logic [mpmem_pkg::BITSROW-1:0]    pipe_srow [mpmem_pkg::SRAM_DELAY];
  logic [mpmem_pkg::BITWRDS-1:0]    pipe_wrd  [mpmem_pkg::SRAM_DELAY];

  assign wr_slot   = {^bk_din, bk_din};  // Even parity on top
  assign t1_writeA = bk_write;
  assign t1_addrA  = bk_wr_srow;
  assign t1_dinA   = {mpmem_pkg::NUMWRDS{wr_slot}};  // Mask picks the live copy
  assign t1_readB  = bk_read;
  assign t1_addrB  = bk_rd_srow;

  always_comb begin
    t1_bwA = '0;
    for (int w = 0; w < mpmem_pkg::NUMWRDS; w++) begin
      if (bk_write && int'(bk_wr_wrd) == w) begin
        t1_bwA[w*mpmem_pkg::MEMWDTH +: mpmem_pkg::MEMWDTH] = '1;
      end
    end
  end

  // Row and slot ride along with the SRAM access
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pipe_vld <= '0;
    end else begin
      pipe_vld[0] <= bk_read;
      for (int i = 1; i < mpmem_pkg::SRAM_DELAY; i++) pipe_vld[i] <= pipe_vld[i-1];
    end
  end

  always_ff @(posedge clk) begin
    pipe_srow[0] <= bk_rd_srow;
    pipe_wrd[0]  <= bk_rd_wrd;
    for (int i = 1; i < mpmem_pkg::SRAM_DELAY; i++) begin
      pipe_srow[i] <= pipe_srow[i-1];
      pipe_wrd[i]  <= pipe_wrd[i-1];
    end
  end

  always_comb begin
    rd_slot = '0;
    for (int w = 0; w < mpmem_pkg::NUMWRDS; w++) begin
      if (int'(pipe_wrd[mpmem_pkg::SRAM_DELAY-1]) == w) begin
        rd_slot = t1_doutB[w*mpmem_pkg::MEMWDTH +: mpmem_pkg::MEMWDTH];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      al_vld <= 1'b0;
    end else begin
      al_vld <= pipe_vld[mpmem_pkg::SRAM_DELAY-1];
    end
  end

  always_ff @(posedge clk) begin
    al_dout <= rd_slot[mpmem_pkg::WIDTH-1:0];
    al_serr <= ^rd_slot;  // Odd count means a flipped bit
    al_padr <= {mpmem_pkg::BITVBNK'(BANK_ID), pipe_srow[mpmem_pkg::SRAM_DELAY-1],
                pipe_wrd[mpmem_pkg::SRAM_DELAY-1]};
  end

  a_no_mask_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
    !t1_writeA |-> t1_bwA == '0);

endmodule

/* src/mpmem_bank_arbiter.sv */
module mpmem_bank_arbiter (
  input  logic                                                   clk,
  input  logic                                                   arst_n,
  input  logic [mpmem_pkg::NUMWRPT-1:0]                          write,
  input  logic [mpmem_pkg::NUMWRPT-1:0][mpmem_pkg::BITADDR-1:0]  wr_adr,
  input  logic [mpmem_pkg::NUMWRPT-1:0][mpmem_pkg::WIDTH-1:0]    din,
  input  logic [mpmem_pkg::NUMRDPT-1:0]                          read,
  input  logic [mpmem_pkg::NUMRDPT-1:0][mpmem_pkg::BITADDR-1:0]  rd_adr,
  output logic [mpmem_pkg::NUMWRPT-1:0]                          wr_gnt,
  output logic [mpmem_pkg::NUMRDPT-1:0]                          rd_gnt,
  output logic                                                   ready,
  output logic [mpmem_pkg::NUMVBNK-1:0]                          bk_write,
  output logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::BITSROW-1:0]  bk_wr_srow,
  output logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::BITWRDS-1:0]  bk_wr_wrd,
  output logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::WIDTH-1:0]    bk_din,
  output logic [mpmem_pkg::NUMVBNK-1:0]                          bk_read,
  output logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::BITSROW-1:0]  bk_rd_srow,
  output logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::BITWRDS-1:0]  bk_rd_wrd,
  output logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::BITRDPT-1:0]  bk_rd_port
);

  mpmem_pkg::mpmem_addr_u wr_a [mpmem_pkg::NUMWRPT];
  mpmem_pkg::mpmem_addr_u rd_a [mpmem_pkg::NUMRDPT];

  logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::MAXPT-1:0] wr_hit;   // Port requests per bank
  logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::MAXPT-1:0] rd_hit;
  logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::MAXPT-1:0] wr_win;   // One-hot winner per bank
  logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::MAXPT-1:0] rd_win;
  logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::MAXPT-1:0] wr_last;  // Last winner, lowest priority
  logic [mpmem_pkg::NUMVBNK-1:0][mpmem_pkg::MAXPT-1:0] rd_last;
  logic                                                init_busy;
  logic [mpmem_pkg::BITINIT-1:0]                       init_cnt;

  // Search starts just after the last winner and wraps at num
  function automatic logic [mpmem_pkg::MAXPT-1:0] rr_pick(
    input logic [mpmem_pkg::MAXPT-1:0] req,
    input logic [mpmem_pkg::MAXPT-1:0] last,
    input int                          num
  );
    logic [mpmem_pkg::MAXPT-1:0] gnt;
    int                          base;
    int                          idx;
    gnt  = '0;
    base = 0;
    for (int i = 0; i < mpmem_pkg::MAXPT; i++) begin
      if (last[i]) base = i;
    end
    for (int k = 1; k <= mpmem_pkg::MAXPT; k++) begin
      idx = (base + k) % num;
      if (k <= num && gnt == '0 && req[idx]) gnt[idx] = 1'b1;
    end
    return gnt;
  endfunction

  always_comb begin
    wr_hit = '0;
    rd_hit = '0;
    for (int p = 0; p < mpmem_pkg::NUMWRPT; p++) begin
      wr_a[p].flat = wr_adr[p];
      wr_hit[wr_a[p].fld.vbnk][p] = write[p];
    end
    for (int p = 0; p < mpmem_pkg::NUMRDPT; p++) begin
      rd_a[p].flat = rd_adr[p];
      rd_hit[rd_a[p].fld.vbnk][p] = read[p];
    end
  end

  always_comb begin
    wr_gnt = '0;
    rd_gnt = '0;
    for (int b = 0; b < mpmem_pkg::NUMVBNK; b++) begin
      wr_win[b] = ready ? rr_pick(wr_hit[b], wr_last[b], mpmem_pkg::NUMWRPT) : '0;
      rd_win[b] = ready ? rr_pick(rd_hit[b], rd_last[b], mpmem_pkg::NUMRDPT) : '0;
      for (int p = 0; p < mpmem_pkg::NUMWRPT; p++) wr_gnt[p] |= wr_win[b][p];
      for (int p = 0; p < mpmem_pkg::NUMRDPT; p++) rd_gnt[p] |= rd_win[b][p];
    end
  end

  // Sweep address and zero data stay on the write side until a port wins
  always_comb begin
    for (int b = 0; b < mpmem_pkg::NUMVBNK; b++) begin
      bk_write[b]   = init_busy | (|wr_win[b]);
      bk_wr_srow[b] = init_cnt[mpmem_pkg::BITWRDS +: mpmem_pkg::BITSROW];
      bk_wr_wrd[b]  = init_cnt[mpmem_pkg::BITWRDS-1:0];
      bk_din[b]     = '0;
      for (int p = 0; p < mpmem_pkg::NUMWRPT; p++) begin
        if (wr_win[b][p]) begin
          bk_wr_srow[b] = wr_a[p].fld.srow;
          bk_wr_wrd[b]  = wr_a[p].fld.wrd;
          bk_din[b]     = din[p];
        end
      end
      bk_read[b]    = |rd_win[b];
      bk_rd_srow[b] = '0;
      bk_rd_wrd[b]  = '0;
      bk_rd_port[b] = '0;
      for (int p = 0; p < mpmem_pkg::NUMRDPT; p++) begin
        if (rd_win[b][p]) begin
          bk_rd_srow[b] = rd_a[p].fld.srow;
          bk_rd_wrd[b]  = rd_a[p].fld.wrd;
          bk_rd_port[b] = mpmem_pkg::BITRDPT'(p);
        end
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      init_busy <= 1'b0;
      init_cnt  <= '0;
      ready     <= 1'b0;
    end else if (!ready) begin
      if (!init_busy) begin
        init_busy <= 1'b1;  // First cycle out of reset
      end else begin
        init_cnt <= init_cnt + 1'b1;
        if (init_cnt == mpmem_pkg::INIT_LAST) begin
          init_busy <= 1'b0;
          ready     <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_last <= '0;
      rd_last <= '0;
    end else begin
      for (int b = 0; b < mpmem_pkg::NUMVBNK; b++) begin
        if (|wr_win[b]) wr_last[b] <= wr_win[b];
        if (|rd_win[b]) rd_last[b] <= rd_win[b];
      end
    end
  end

  for (genvar b = 0; b < mpmem_pkg::NUMVBNK; b++) begin : g_chk
    a_one_wr_per_bank: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0(wr_gnt & wr_hit[b][mpmem_pkg::NUMWRPT-1:0]));
  end

endmodule

/* src/mpmem_pkg.sv */
package mpmem_pkg;

  // Port counts
  localparam int NUMWRPT = 2;
  localparam int NUMRDPT = 2;
  localparam int BITRDPT = 1;
  localparam int MAXPT   = (NUMWRPT > NUMRDPT) ? NUMWRPT : NUMRDPT;  // Arbiter request width

  // Data word
  localparam int WIDTH   = 16;
  localparam int MEMWDTH = WIDTH + 1;        // Word plus even parity

  // Banks and physical rows
  localparam int NUMVBNK = 4;
  localparam int BITVBNK = 2;
  localparam int NUMWRDS = 2;                // Words packed per row
  localparam int BITWRDS = 1;
  localparam int NUMSROW = 16;
  localparam int BITSROW = 4;
  localparam int PHYWDTH = NUMWRDS * MEMWDTH;

  // Addresses
  localparam int BITADDR = BITSROW + BITWRDS + BITVBNK;
  localparam int BITPADR = BITVBNK + BITSROW + BITWRDS;  // {bank, row, word}

  // Timing
  localparam int SRAM_DELAY = 1;
  localparam int RD_LAT     = SRAM_DELAY + 1;

  // Init sweep covers every word slot of a bank
  localparam int INIT_CYCLES = NUMSROW * NUMWRDS;
  localparam int BITINIT     = BITSROW + BITWRDS;
  localparam logic [BITINIT-1:0] INIT_LAST = BITINIT'(INIT_CYCLES - 1);

  // Bank index sits in the low bits so neighbouring addresses spread over banks
  typedef struct packed {
    logic [BITSROW-1:0] srow;
    logic [BITWRDS-1:0] wrd;
    logic [BITVBNK-1:0] vbnk;
  } mpmem_addr_s;

  typedef union packed {
    logic [BITADDR-1:0] flat;
    mpmem_addr_s        fld;
  } mpmem_addr_u;

endpackage
